// ==== src/pipe_stage_pkg.sv ====
package pipe_stage_pkg;

    // Pipeline stage of a traced instruction
    // EMPTY marks a slot with no instruction in it
    typedef enum logic [2:0] {
        EMPTY     = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXECUTE   = 3'd3,
        MEMORY    = 3'd4,
        WRITEBACK = 3'd5
    } stage_t;

    // Instruction class carried with each instruction
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } opcode_t;

    // Number of pipeline stages, fetch through writeback
    // Also the issue to retire latency when nothing stalls
    localparam int NUM_STAGES = 5;

endpackage

// ==== src/trace_record_pkg.sv ====
package trace_record_pkg;

    // Instruction id width
    localparam int ID_W = 8;

    // Per-record stall count width, saturates at all ones
    localparam int STALL_W = 8;

    // Register and event counter width
    localparam int CNT_W = 16;

    // Bits of the control register
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

    // Register map of the trace control block
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,
        REG_RETIRED = 2'd1,
        REG_STALLS  = 2'd2,
        REG_DROPS   = 2'd3
    } reg_addr_t;

endpackage

// ==== src/trace_record_if.sv ====
`timescale 1ns/1ns

// One retire record, passed from the tracker to the record FIFO
interface trace_record_if #(
    parameter int CYCLE_W = 16
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    // Single-cycle strobe, fields valid only while it is high
    logic                valid;
    logic [ID_W-1:0]     id;
    opcode_t             opcode;
    logic [CYCLE_W-1:0]  fetch_cycle;
    logic [CYCLE_W-1:0]  retire_cycle;
    logic [STALL_W-1:0]  stall_cycles;

    modport source (
        output valid, id, opcode, fetch_cycle, retire_cycle, stall_cycles
    );

    modport sink (
        input valid, id, opcode, fetch_cycle, retire_cycle, stall_cycles
    );

endinterface

// ==== src/stage_tracker.sv ====
`timescale 1ns/1ns

module stage_tracker #(
    parameter int CYCLE_W = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              issue,
    input  logic [trace_record_pkg::ID_W-1:0] issue_id,
    input  pipe_stage_pkg::opcode_t           issue_opcode,
    input  logic                              stall,
    input  logic                              enable,
    output logic                              retire_pulse,
    output logic                              stall_cycle_pulse,
    trace_record_if.source                    rec
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    // One slot per stage, indexed by the stage encoding
    logic                slot_occ    [1:NUM_STAGES];
    logic [ID_W-1:0]     slot_id     [1:NUM_STAGES];
    opcode_t             slot_opcode [1:NUM_STAGES];
    logic [CYCLE_W-1:0]  slot_fetch  [1:NUM_STAGES];
    logic [STALL_W-1:0]  slot_stall  [1:NUM_STAGES];

    // Free-running cycle count, wraps at CYCLE_W bits
    logic [CYCLE_W-1:0]  cycle_cnt;

    logic                retire_now;

    function automatic logic [STALL_W-1:0] stall_inc(input logic [STALL_W-1:0] cnt);
        return (&cnt) ? cnt : cnt + 1'b1;
    endfunction

    // Record only while tracing is enabled
    assign retire_now = slot_occ[WRITEBACK] && enable;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Occupancy per stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 1; s <= NUM_STAGES; s++) begin
                slot_occ[s] <= 1'b0;
            end
        end else begin
            // Back stages always drain
            slot_occ[WRITEBACK] <= slot_occ[MEMORY];
            slot_occ[MEMORY]    <= slot_occ[EXECUTE];
            // A stall sends a bubble into execute
            slot_occ[EXECUTE]   <= slot_occ[DECODE] && !stall;
            if (!stall) begin
                slot_occ[DECODE] <= slot_occ[FETCH];
                slot_occ[FETCH]  <= issue;
            end
        end
    end

    // Instruction payload moves with its occupancy bit
    always_ff @(posedge clk) begin
        slot_id[WRITEBACK]     <= slot_id[MEMORY];
        slot_opcode[WRITEBACK] <= slot_opcode[MEMORY];
        slot_fetch[WRITEBACK]  <= slot_fetch[MEMORY];
        slot_stall[WRITEBACK]  <= slot_stall[MEMORY];

        slot_id[MEMORY]        <= slot_id[EXECUTE];
        slot_opcode[MEMORY]    <= slot_opcode[EXECUTE];
        slot_fetch[MEMORY]     <= slot_fetch[EXECUTE];
        slot_stall[MEMORY]     <= slot_stall[EXECUTE];

        slot_id[EXECUTE]       <= slot_id[DECODE];
        slot_opcode[EXECUTE]   <= slot_opcode[DECODE];
        slot_fetch[EXECUTE]    <= slot_fetch[DECODE];
        slot_stall[EXECUTE]    <= slot_stall[DECODE];

        if (stall) begin
            // Front stages hold and their occupants are charged a cycle
            slot_stall[FETCH]  <= stall_inc(slot_stall[FETCH]);
            slot_stall[DECODE] <= stall_inc(slot_stall[DECODE]);
        end else begin
            slot_id[DECODE]     <= slot_id[FETCH];
            slot_opcode[DECODE] <= slot_opcode[FETCH];
            slot_fetch[DECODE]  <= slot_fetch[FETCH];
            slot_stall[DECODE]  <= slot_stall[FETCH];

            if (issue) begin
                slot_id[FETCH]     <= issue_id;
                slot_opcode[FETCH] <= issue_opcode;
                slot_fetch[FETCH]  <= cycle_cnt;
                slot_stall[FETCH]  <= '0;
            end
        end
    end

    // Retire strobes and the stall event pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec.valid         <= 1'b0;
            retire_pulse      <= 1'b0;
            stall_cycle_pulse <= 1'b0;
        end else begin
            rec.valid         <= retire_now;
            retire_pulse      <= retire_now;
            stall_cycle_pulse <= stall && enable;
        end
    end

    // Record fields, taken from the writeback slot as it leaves
    always_ff @(posedge clk) begin
        if (retire_now) begin
            rec.id           <= slot_id[WRITEBACK];
            rec.opcode       <= slot_opcode[WRITEBACK];
            rec.fetch_cycle  <= slot_fetch[WRITEBACK];
            rec.retire_cycle <= cycle_cnt;
            rec.stall_cycles <= slot_stall[WRITEBACK];
        end
    end

endmodule

// ==== src/trace_ctrl_regs.sv ====
`timescale 1ns/1ns

module trace_ctrl_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               reg_wr,
    input  logic                               reg_rd,
    input  trace_record_pkg::reg_addr_t        reg_addr,
    input  logic [trace_record_pkg::CNT_W-1:0] reg_wdata,
    output logic [trace_record_pkg::CNT_W-1:0] reg_rdata,
    input  logic                               retire_pulse,
    input  logic                               stall_cycle_pulse,
    input  logic                               drop_pulse,
    output logic                               enable
);
    import trace_record_pkg::*;

    logic              ctrl_wr;
    logic              clear;
    logic [CNT_W-1:0]  retired_cnt;
    logic [CNT_W-1:0]  stall_cnt;
    logic [CNT_W-1:0]  drop_cnt;

    // Saturating increment
    function automatic logic [CNT_W-1:0] count_up(input logic [CNT_W-1:0] cnt,
                                                  input logic hit);
        return (hit && !(&cnt)) ? cnt + 1'b1 : cnt;
    endfunction

    assign ctrl_wr = reg_wr && (reg_addr == REG_CTRL);
    assign clear   = ctrl_wr && reg_wdata[CTRL_CLR_BIT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable <= 1'b1;
        end else if (ctrl_wr) begin
            enable <= reg_wdata[CTRL_EN_BIT];
        end
    end

    // Event counters, a clear wins over a same-cycle event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired_cnt <= '0;
            stall_cnt   <= '0;
            drop_cnt    <= '0;
        end else if (clear) begin
            retired_cnt <= '0;
            stall_cnt   <= '0;
            drop_cnt    <= '0;
        end else begin
            retired_cnt <= count_up(retired_cnt, retire_pulse);
            stall_cnt   <= count_up(stall_cnt, stall_cycle_pulse);
            drop_cnt    <= count_up(drop_cnt, drop_pulse);
        end
    end

    // Registered readback, one cycle after the read strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                REG_CTRL:    reg_rdata <= {{(CNT_W-1){1'b0}}, enable};
                REG_RETIRED: reg_rdata <= retired_cnt;
                REG_STALLS:  reg_rdata <= stall_cnt;
                REG_DROPS:   reg_rdata <= drop_cnt;
                default:     reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== src/retire_fifo.sv ====
`timescale 1ns/1ns

module retire_fifo #(
    parameter int CYCLE_W    = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    trace_record_if.sink                         rec,
    input  logic                                 pop,
    output logic                                 rec_valid,
    output logic [trace_record_pkg::ID_W-1:0]    rec_id,
    output pipe_stage_pkg::opcode_t              rec_opcode,
    output logic [CYCLE_W-1:0]                   rec_fetch_cycle,
    output logic [CYCLE_W-1:0]                   rec_retire_cycle,
    output logic [trace_record_pkg::STALL_W-1:0] rec_stall_cycles,
    output logic                                 drop_pulse
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [ID_W-1:0]     mem_id     [FIFO_DEPTH];
    opcode_t             mem_opcode [FIFO_DEPTH];
    logic [CYCLE_W-1:0]  mem_fetch  [FIFO_DEPTH];
    logic [CYCLE_W-1:0]  mem_retire [FIFO_DEPTH];
    logic [STALL_W-1:0]  mem_stall  [FIFO_DEPTH];

    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         fill;
    logic                full;
    logic                push;
    logic                do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (fill == (AW+1)'(FIFO_DEPTH));
    assign rec_valid = (fill != '0);
    assign push      = rec.valid && !full;
    assign do_pop    = pop && rec_valid;

    // Head of the queue
    assign rec_id           = mem_id[rd_ptr];
    assign rec_opcode       = mem_opcode[rd_ptr];
    assign rec_fetch_cycle  = mem_fetch[rd_ptr];
    assign rec_retire_cycle = mem_retire[rd_ptr];
    assign rec_stall_cycles = mem_stall[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_id[wr_ptr]     <= rec.id;
            mem_opcode[wr_ptr] <= rec.opcode;
            mem_fetch[wr_ptr]  <= rec.fetch_cycle;
            mem_retire[wr_ptr] <= rec.retire_cycle;
            mem_stall[wr_ptr]  <= rec.stall_cycles;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            drop_pulse <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill       <= fill + (AW+1)'(push) - (AW+1)'(do_pop);
            // A record that finds the queue full is lost
            drop_pulse <= rec.valid && full;
        end
    end

endmodule

// ==== src/pipe_trace_top.sv ====
`timescale 1ns/1ns

module pipe_trace_top #(
    parameter int CYCLE_W    = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue,
    input  logic [trace_record_pkg::ID_W-1:0]    issue_id,
    input  pipe_stage_pkg::opcode_t              issue_opcode,
    input  logic                                 stall,
    input  logic                                 pop,
    input  logic                                 reg_wr,
    input  logic                                 reg_rd,
    input  trace_record_pkg::reg_addr_t          reg_addr,
    input  logic [trace_record_pkg::CNT_W-1:0]   reg_wdata,
    output logic                                 rec_valid,
    output logic [trace_record_pkg::ID_W-1:0]    rec_id,
    output pipe_stage_pkg::opcode_t              rec_opcode,
    output logic [CYCLE_W-1:0]                   rec_fetch_cycle,
    output logic [CYCLE_W-1:0]                   rec_retire_cycle,
    output logic [trace_record_pkg::STALL_W-1:0] rec_stall_cycles,
    output logic [trace_record_pkg::CNT_W-1:0]   reg_rdata
);

    logic enable;
    logic retire_pulse;
    logic stall_cycle_pulse;
    logic drop_pulse;

    // Retire records from tracker to queue
    trace_record_if #(.CYCLE_W(CYCLE_W)) rec_if ();

    stage_tracker #(
        .CYCLE_W(CYCLE_W)
    ) u_tracker (
        .clk               (clk),
        .rst               (rst),
        .issue             (issue),
        .issue_id          (issue_id),
        .issue_opcode      (issue_opcode),
        .stall             (stall),
        .enable            (enable),
        .retire_pulse      (retire_pulse),
        .stall_cycle_pulse (stall_cycle_pulse),
        .rec               (rec_if.source)
    );

    trace_ctrl_regs u_regs (
        .clk               (clk),
        .rst               (rst),
        .reg_wr            (reg_wr),
        .reg_rd            (reg_rd),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_rdata         (reg_rdata),
        .retire_pulse      (retire_pulse),
        .stall_cycle_pulse (stall_cycle_pulse),
        .drop_pulse        (drop_pulse),
        .enable            (enable)
    );

    retire_fifo #(
        .CYCLE_W    (CYCLE_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk              (clk),
        .rst              (rst),
        .rec              (rec_if.sink),
        .pop              (pop),
        .rec_valid        (rec_valid),
        .rec_id           (rec_id),
        .rec_opcode       (rec_opcode),
        .rec_fetch_cycle  (rec_fetch_cycle),
        .rec_retire_cycle (rec_retire_cycle),
        .rec_stall_cycles (rec_stall_cycles),
        .drop_pulse       (drop_pulse)
    );

endmodule

// ==== verification/pipe_trace_assertions.sv ====
`timescale 1ns/1ns

// Protocol checks on the trace unit ports
module pipe_trace_assertions #(
    parameter int CYCLE_W = 16
) (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 issue,
    input logic                                 stall,
    input logic                                 pop,
    input logic                                 rec_valid,
    input logic [CYCLE_W-1:0]                   rec_fetch_cycle,
    input logic [CYCLE_W-1:0]                   rec_retire_cycle,
    input logic [trace_record_pkg::STALL_W-1:0] rec_stall_cycles
);
    import pipe_stage_pkg::*;

    logic [CYCLE_W-1:0] span;
    logic [CYCLE_W-1:0] latency;
    int                 failures = 0;

    // Both wrap at CYCLE_W bits like the cycle counter
    assign span    = rec_retire_cycle - rec_fetch_cycle;
    assign latency = CYCLE_W'(NUM_STAGES) + CYCLE_W'(rec_stall_cycles);

    // An issue under stall is ignored by the tracker
    issue_not_stalled: assert property (@(posedge clk) disable iff (rst) !(issue && stall))
        else begin
            $error("issue high while stall is high");
            failures++;
        end

    pop_only_when_valid: assert property (@(posedge clk) disable iff (rst) !(pop && !rec_valid))
        else begin
            $error("pop high while the record FIFO is empty");
            failures++;
        end

    record_latency: assert property (@(posedge clk) disable iff (rst)
                                     rec_valid |-> span == latency)
        else begin
            $error("record span %h does not match latency %h", span, latency);
            failures++;
        end

endmodule

bind pipe_trace_top pipe_trace_assertions #(.CYCLE_W(CYCLE_W)) u_assertions (
    .clk              (clk),
    .rst              (rst),
    .issue            (issue),
    .stall            (stall),
    .pop              (pop),
    .rec_valid        (rec_valid),
    .rec_fetch_cycle  (rec_fetch_cycle),
    .rec_retire_cycle (rec_retire_cycle),
    .rec_stall_cycles (rec_stall_cycles)
);

// ==== verification/tb_pipe_trace.sv ====
`timescale 1ns/1ns

module tb_pipe_trace;
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    localparam int CYCLE_W    = 16;
    localparam int MAX_CYCLES = 2000;
    localparam int WAIT_LIMIT = 30;

    logic                clk = 1'b0;
    logic                rst;
    logic                issue;
    logic [ID_W-1:0]     issue_id;
    opcode_t             issue_opcode;
    logic                stall;
    logic                pop;
    logic                reg_wr;
    logic                reg_rd;
    reg_addr_t           reg_addr;
    logic [CNT_W-1:0]    reg_wdata;
    logic                rec_valid;
    logic [ID_W-1:0]     rec_id;
    opcode_t             rec_opcode;
    logic [CYCLE_W-1:0]  rec_fetch_cycle;
    logic [CYCLE_W-1:0]  rec_retire_cycle;
    logic [STALL_W-1:0]  rec_stall_cycles;
    logic [CNT_W-1:0]    reg_rdata;

    // Reference model state
    logic [CYCLE_W-1:0]  cyc;
    int                  run_cycles = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  exp_retired = 0;
    int                  exp_stalls = 0;
    bit                  tb_enable = 1'b1;
    logic [ID_W-1:0]     exp_id    [$];
    opcode_t             exp_op    [$];
    logic [CYCLE_W-1:0]  exp_fetch [$];
    logic [STALL_W-1:0]  exp_stall [$];

    pipe_trace_top #(.CYCLE_W(CYCLE_W), .FIFO_DEPTH(8)) u_dut (.*);

    always #5 clk = ~clk;

    // Cycle count as the tracker sees it from reset
    always @(posedge clk) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1'b1;
        end
        run_cycles <= run_cycles + 1;
        if (run_cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests finished", run_cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [ID_W-1:0] rand_id();
        return ID_W'($urandom);
    endfunction

    function automatic opcode_t rand_op();
        logic [1:0] v;
        v = 2'($urandom_range(0, 3));
        return opcode_t'(v);
    endfunction

    // One issue at the next edge; keep marks a record the FIFO should hold
    task automatic issue_one(input logic [ID_W-1:0] id, input opcode_t op,
                             input int exp_s, input bit keep);
        issue        = 1'b1;
        issue_id     = id;
        issue_opcode = op;
        if (keep) begin
            exp_id.push_back(id);
            exp_op.push_back(op);
            exp_fetch.push_back(cyc);
            exp_stall.push_back(STALL_W'(exp_s));
        end
        if (tb_enable) begin
            exp_retired++;
        end
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic stall_for(input int n);
        stall = 1'b1;
        repeat (n) @(negedge clk);
        stall = 1'b0;
        if (tb_enable) begin
            exp_stalls += n;
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [CNT_W-1:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_check(input reg_addr_t addr, input logic [CNT_W-1:0] want);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        checks++;
        if (reg_rdata !== want) begin
            errors++;
            $display("FAILED reg_rdata %s: got %h expected %h", addr.name(), reg_rdata, want);
        end
    endtask

    // Pop n records and compare each with the oldest expected one
    task automatic drain(input int n);
        int                  waited;
        logic [CYCLE_W-1:0]  want_ret;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            while (!rec_valid && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            checks++;
            if (!rec_valid || exp_id.size() == 0) begin
                errors++;
                $display("Expected record %0d of %0d never came out of the FIFO", i + 1, n);
                return;
            end
            want_ret = exp_fetch[0] + CYCLE_W'(NUM_STAGES) + CYCLE_W'(exp_stall[0]);
            if (rec_id !== exp_id[0]) begin
                errors++;
                $display("FAILED rec_id: got %h expected %h", rec_id, exp_id[0]);
            end
            if (rec_opcode !== exp_op[0]) begin
                errors++;
                $display("FAILED rec_opcode: got %h expected %h", rec_opcode, exp_op[0]);
            end
            if (rec_fetch_cycle !== exp_fetch[0]) begin
                errors++;
                $display("FAILED rec_fetch_cycle: got %h expected %h",
                         rec_fetch_cycle, exp_fetch[0]);
            end
            if (rec_retire_cycle !== want_ret) begin
                errors++;
                $display("FAILED rec_retire_cycle: got %h expected %h",
                         rec_retire_cycle, want_ret);
            end
            if (rec_stall_cycles !== exp_stall[0]) begin
                errors++;
                $display("FAILED rec_stall_cycles: got %h expected %h",
                         rec_stall_cycles, exp_stall[0]);
            end
            void'(exp_id.pop_front());
            void'(exp_op.pop_front());
            void'(exp_fetch.pop_front());
            void'(exp_stall.pop_front());
            pop = 1'b1;
            @(negedge clk);
            pop = 1'b0;
        end
    endtask

    task automatic expect_empty();
        checks++;
        if (rec_valid || exp_id.size() != 0) begin
            errors++;
            $display("Leftover records after draining: rec_valid %0b, %0d still expected",
                     rec_valid, exp_id.size());
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic single_issue();
        int e0;
        e0 = errors;
        issue_one(rand_id(), rand_op(), 0, 1'b1);
        drain(1);
        expect_empty();
        report("single issue", e0);
    endtask

    task automatic back_to_back_issues();
        int e0;
        e0 = errors;
        repeat (5) issue_one(rand_id(), rand_op(), 0, 1'b1);
        drain(5);
        expect_empty();
        report("back to back issues", e0);
    endtask

    // Oldest is in execute when the stall starts and the other two hold
    task automatic front_stall();
        int e0;
        int s;
        e0 = errors;
        s  = $urandom_range(1, 6);
        issue_one(rand_id(), rand_op(), 0, 1'b1);
        issue_one(rand_id(), rand_op(), s, 1'b1);
        issue_one(rand_id(), rand_op(), s, 1'b1);
        stall_for(s);
        drain(3);
        expect_empty();
        report("front stall", e0);
    endtask

    task automatic disabled_tracing();
        int e0;
        e0 = errors;
        reg_write(REG_CTRL, 16'h0000);
        tb_enable = 1'b0;
        reg_check(REG_CTRL, 16'h0000);
        repeat (3) issue_one(rand_id(), rand_op(), 0, 1'b0);
        repeat (12) begin
            @(negedge clk);
            checks++;
            if (rec_valid) begin
                errors++;
                $display("A record reached the FIFO while tracing was disabled");
            end
        end
        reg_write(REG_CTRL, 16'h0001);
        tb_enable = 1'b1;
        issue_one(rand_id(), rand_op(), 0, 1'b1);
        drain(1);
        expect_empty();
        report("tracing disabled", e0);
    endtask

    task automatic fifo_overflow();
        int e0;
        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            issue_one(rand_id(), rand_op(), 0, i < 8);
        end
        repeat (12) @(negedge clk);
        reg_check(REG_DROPS, 16'd2);
        drain(8);
        expect_empty();
        report("fifo overflow", e0);
    endtask

    task automatic counter_readback();
        int e0;
        e0 = errors;
        stall_for(3);
        repeat (2) @(negedge clk);
        reg_check(REG_RETIRED, CNT_W'(exp_retired));
        reg_check(REG_STALLS, CNT_W'(exp_stalls));
        // Keep enable set while clearing
        reg_write(REG_CTRL, 16'h0003);
        reg_check(REG_RETIRED, 16'd0);
        reg_check(REG_STALLS, 16'd0);
        reg_check(REG_DROPS, 16'd0);
        report("register readback", e0);
    endtask

    initial begin
        rst          = 1'b1;
        issue        = 1'b0;
        issue_id     = '0;
        issue_opcode = OP_ALU;
        stall        = 1'b0;
        pop          = 1'b0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = REG_CTRL;
        reg_wdata    = '0;
        void'($urandom(32'h5eac_83ac));
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        single_issue();
        back_to_back_issues();
        front_stall();
        disabled_tracing();
        fifo_overflow();
        counter_readback();
        errors += u_dut.u_assertions.failures;
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
src/pipe_stage_pkg.sv
src/trace_record_pkg.sv
src/trace_record_if.sv
src/stage_tracker.sv
src/trace_ctrl_regs.sv
src/retire_fifo.sv
src/pipe_trace_top.sv
verification/pipe_trace_assertions.sv
verification/tb_pipe_trace.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_pipe_trace
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
